/* Bender.yml */
package:
  name: norm_round_unit

sources:
  - files:
      - source/fp_format_pkg.sv
      - source/fp_round_pkg.sv
      - source/norm_special_case.sv
      - source/norm_mant_align.sv
      - source/norm_round_pack.sv
      - source/norm_round_unit.sv
  - target: test
    files:
      - test/norm_round_unit_assertions.sv
      - test/tb_norm_round_unit.sv

/* source/fp_format_pkg.sv */
// Format widths, exponent limits, extended operand types, format and operation enums
`default_nettype none

package fp_format_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Field widths
  ////////////////////////////////////////////////////////////////////////////
  localparam int unsigned MANT_W   = 23;  // FP32 stored mantissa
  localparam int unsigned EXP_W    = 8;   // FP32 exponent
  localparam int unsigned MANT16_W = 10;  // FP16 stored mantissa
  localparam int unsigned EXP16_W  = 5;   // FP16 exponent

  // Hidden bit + mantissa + 4 rounding bits
  localparam int unsigned MANT_EXT_W = MANT_W + 5;
  // Alignment window, room for a full denormal shift-out
  localparam int unsigned ALIGN_W    = 2 * MANT_EXT_W;

  // Biased exponent at which a format saturates to infinity
  localparam int unsigned EXP_MAX32 = (1 << EXP_W) - 1;    // 255
  localparam int unsigned EXP_MAX16 = (1 << EXP16_W) - 1;  // 31

  ////////////////////////////////////////////////////////////////////////////
  // Operand types
  ////////////////////////////////////////////////////////////////////////////
  typedef logic [MANT_EXT_W-1:0]     mant_ext_t;  // Not yet normalized
  typedef logic signed [EXP_W+1:0]   exp_ext_t;   // Biased, may go negative

  typedef enum logic {
    FMT_FP32,
    FMT_FP16   // NaN-boxed into 32 bits
  } fmt_e;

  typedef enum logic {
    OP_DIV,
    OP_SQRT
  } op_e;

endpackage

`default_nettype wire

/* source/fp_round_pkg.sv */
// Rounding mode enum, exception flag type, result type and canonical NaN constants
`default_nettype none

package fp_round_pkg;

  // IEEE rounding directions
  typedef enum logic [2:0] {
    RM_RNE = 3'd0,  // Nearest, ties to even
    RM_RTZ = 3'd1,  // Toward zero
    RM_RDN = 3'd2,  // Toward -inf
    RM_RUP = 3'd3   // Toward +inf
  } rm_e;

  // Exception flags, nv in the top bit
  typedef struct packed {
    logic nv;  // Invalid operation
    logic dz;  // Divide by zero
    logic of;  // Overflow
    logic uf;  // Underflow
    logic nx;  // Inexact
  } flags_t;

  typedef logic [31:0] result_t;

  // Upper half filler for FP16 results
  localparam logic [15:0] BOX16 = 16'hffff;

  // Canonical quiet NaNs
  localparam result_t QNAN32 = 32'h7fc0_0000;
  localparam result_t QNAN16 = {BOX16, 16'h7e00};

endpackage

`default_nettype wire

/* source/norm_mant_align.sv */
// Normalization and denormal right shift giving kept mantissa, guard bits, sticky and exponent
`default_nettype none

module norm_mant_align (
  input  fp_format_pkg::mant_ext_t        mant_in,
  input  fp_format_pkg::exp_ext_t         exp_in,
  input  fp_format_pkg::fmt_e             fmt,
  output logic [fp_format_pkg::MANT_W:0]  norm_mant,   // Hidden bit on top
  output logic [fp_format_pkg::EXP_W-1:0] norm_exp,
  output logic [1:0]                      round_bits,  // Guard, round
  output logic                            sticky,
  output logic                            uf_hint      // Result is denormal
);

  logic                                msb;         // 1.xxx form
  logic                                dnrm;
  fp_format_pkg::exp_ext_t             exp_dec;
  logic [fp_format_pkg::EXP_W+1:0]     rshift_raw;
  logic [4:0]                          rshift;
  logic [fp_format_pkg::ALIGN_W-1:0]   aligned;

  assign msb     = mant_in[fp_format_pkg::MANT_EXT_W-1];
  assign exp_dec = exp_in - fp_format_pkg::exp_ext_t'(1);

  // Denormal below exponent 1, or at 1 when the left shift would drop it to 0
  assign dnrm = (exp_in < fp_format_pkg::exp_ext_t'(1)) ||
                ((exp_in == fp_format_pkg::exp_ext_t'(1)) && !msb);

  ////////////////////////////////////////////////////////////////////////////
  // Denormal shift amount, 1 - exp
  ////////////////////////////////////////////////////////////////////////////
  assign rshift_raw = fp_format_pkg::exp_ext_t'(1) - exp_in;  // Only used when exp <= 1

  // Past the window everything is sticky anyway
  assign rshift = (rshift_raw > fp_format_pkg::MANT_EXT_W) ?
                  5'(fp_format_pkg::MANT_EXT_W) : rshift_raw[4:0];

  always_comb
  begin
    if (dnrm)
      aligned = {mant_in, {fp_format_pkg::MANT_EXT_W{1'b0}}} >> rshift;
    else if (!msb)
      // 0.1xx, one step left
      aligned = {mant_in[fp_format_pkg::MANT_EXT_W-2:0],
                 {(fp_format_pkg::MANT_EXT_W + 1){1'b0}}};
    else
      aligned = {mant_in, {fp_format_pkg::MANT_EXT_W{1'b0}}};
  end

  always_comb
  begin
    if (dnrm)
      norm_exp = '0;
    else if (!msb)
      norm_exp = exp_dec[fp_format_pkg::EXP_W-1:0];  // Compensate left shift
    else
      norm_exp = exp_in[fp_format_pkg::EXP_W-1:0];
  end

  // Kept bits are always the top of the window
  assign norm_mant = aligned[fp_format_pkg::ALIGN_W-1 -: fp_format_pkg::MANT_W+1];

  ////////////////////////////////////////////////////////////////////////////
  // Guard, round and sticky below the format LSB
  ////////////////////////////////////////////////////////////////////////////
  always_comb
  begin
    if (fmt == fp_format_pkg::FMT_FP16)
    begin
      round_bits = aligned[fp_format_pkg::ALIGN_W-fp_format_pkg::MANT16_W-2 -: 2];
      sticky     = |aligned[fp_format_pkg::ALIGN_W-fp_format_pkg::MANT16_W-4:0];
    end
    else
    begin
      round_bits = aligned[fp_format_pkg::ALIGN_W-fp_format_pkg::MANT_W-2 -: 2];
      sticky     = |aligned[fp_format_pkg::ALIGN_W-fp_format_pkg::MANT_W-4:0];
    end
  end

  assign uf_hint = dnrm;

endmodule

`default_nettype wire

/* source/norm_round_pack.sv */
// Round-up decision, increment with renormalization, packing with FP16 NaN boxing
`default_nettype none

module norm_round_pack (
  input  logic [fp_format_pkg::MANT_W:0]  norm_mant,
  input  logic [fp_format_pkg::EXP_W-1:0] norm_exp,
  input  logic [1:0]                      round_bits,
  input  logic                            sticky,
  input  logic                            uf_hint,
  input  logic                            sign,
  input  fp_round_pkg::rm_e               rm,
  input  fp_format_pkg::fmt_e             fmt,
  output fp_round_pkg::result_t           round_result,
  output fp_round_pkg::flags_t            round_flags
);

  logic                                is16;
  logic                                lsb;       // LSB at format boundary
  logic                                inexact;
  logic                                round_up;
  logic [fp_format_pkg::MANT_W+1:0]    inc;
  logic [fp_format_pkg::MANT_W+1:0]    mant_sum;  // Extra bit for carry out
  logic                                renorm;
  logic [fp_format_pkg::MANT_W:0]      mant_rnd;
  logic [fp_format_pkg::EXP_W-1:0]     exp_rnd;
  logic                                ovf;

  assign is16    = (fmt == fp_format_pkg::FMT_FP16);
  assign lsb     = is16 ? norm_mant[fp_format_pkg::MANT_W-fp_format_pkg::MANT16_W] :
                          norm_mant[0];
  assign inexact = (|round_bits) | sticky;

  ////////////////////////////////////////////////////////////////////////////
  // Rounding direction
  ////////////////////////////////////////////////////////////////////////////
  always_comb
  begin
    case (rm)
      fp_round_pkg::RM_RNE: round_up = round_bits[1] & (round_bits[0] | sticky | lsb);
      fp_round_pkg::RM_RTZ: round_up = 1'b0;
      fp_round_pkg::RM_RDN: round_up = inexact & sign;   // Magnitude up when negative
      fp_round_pkg::RM_RUP: round_up = inexact & ~sign;
      default:              round_up = 1'b0;
    endcase
  end

  // One unit at the format LSB
  always_comb
  begin
    inc = '0;
    if (is16)
      inc[fp_format_pkg::MANT_W-fp_format_pkg::MANT16_W] = round_up;
    else
      inc[0] = round_up;
  end

  assign mant_sum = {1'b0, norm_mant} + inc;
  assign renorm   = mant_sum[fp_format_pkg::MANT_W+1];  // 1.111.. + 1 carried out

  assign mant_rnd = renorm ? mant_sum[fp_format_pkg::MANT_W+1:1] :
                             mant_sum[fp_format_pkg::MANT_W:0];

  // Denormal rounding into the hidden bit becomes the smallest normal
  always_comb
  begin
    if (uf_hint)
      exp_rnd = {{(fp_format_pkg::EXP_W-1){1'b0}}, mant_sum[fp_format_pkg::MANT_W]};
    else
      exp_rnd = norm_exp + {{(fp_format_pkg::EXP_W-1){1'b0}}, renorm};
  end

  // Carry into the all-ones exponent, mantissa is zero here so this is infinity
  assign ovf = is16 ? (exp_rnd[fp_format_pkg::EXP16_W-1:0] == '1) : (exp_rnd == '1);

  ////////////////////////////////////////////////////////////////////////////
  // Packing
  ////////////////////////////////////////////////////////////////////////////
  always_comb
  begin
    if (is16)
      round_result = {fp_round_pkg::BOX16, sign,
                      exp_rnd[fp_format_pkg::EXP16_W-1:0],
                      mant_rnd[fp_format_pkg::MANT_W-1 -: fp_format_pkg::MANT16_W]};
    else
      round_result = {sign, exp_rnd, mant_rnd[fp_format_pkg::MANT_W-1:0]};
  end

  always_comb
  begin
    round_flags    = '0;
    round_flags.of = ovf;
    round_flags.uf = uf_hint;
    round_flags.nx = inexact;  // Always rounding, only discarded bits count
  end

endmodule

`default_nettype wire

/* source/norm_round_unit.sv */
// Top level with special path, normalize and round path, result select and output register
`default_nettype none

module norm_round_unit (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      in_valid,  // One-cycle strobe
  input  fp_format_pkg::op_e        op,
  input  fp_format_pkg::fmt_e       fmt,
  input  fp_round_pkg::rm_e         rm,
  input  logic                      sign,
  input  fp_format_pkg::mant_ext_t  mant_in,
  input  fp_format_pkg::exp_ext_t   exp_in,
  input  logic                      nan_a,
  input  logic                      nan_b,
  input  logic                      snan,
  input  logic                      inf_a,
  input  logic                      inf_b,
  input  logic                      zero_a,
  input  logic                      zero_b,
  output logic                      out_valid,
  output fp_round_pkg::result_t     result,
  output fp_round_pkg::flags_t      flags
);

  logic                              special_hit;
  fp_round_pkg::result_t             special_result;
  fp_round_pkg::flags_t              special_flags;
  logic [fp_format_pkg::MANT_W:0]    norm_mant;
  logic [fp_format_pkg::EXP_W-1:0]   norm_exp;
  logic [1:0]                        round_bits;
  logic                              sticky;
  logic                              uf_hint;
  fp_round_pkg::result_t             round_result;
  fp_round_pkg::flags_t              round_flags;
  fp_round_pkg::result_t             sel_result;
  fp_round_pkg::flags_t              sel_flags;

  ////////////////////////////////////////////////////////////////////////////
  // Datapath, all combinational
  ////////////////////////////////////////////////////////////////////////////
  norm_special_case u_special (
    .op(op), .sign(sign), .exp_in(exp_in), .fmt(fmt),
    .nan_a(nan_a), .nan_b(nan_b), .snan(snan),
    .inf_a(inf_a), .inf_b(inf_b), .zero_a(zero_a), .zero_b(zero_b),
    .special_hit(special_hit), .special_result(special_result),
    .special_flags(special_flags)
  );

  norm_mant_align u_align (
    .mant_in(mant_in), .exp_in(exp_in), .fmt(fmt),
    .norm_mant(norm_mant), .norm_exp(norm_exp), .round_bits(round_bits),
    .sticky(sticky), .uf_hint(uf_hint)
  );

  norm_round_pack u_round (
    .norm_mant(norm_mant), .norm_exp(norm_exp), .round_bits(round_bits),
    .sticky(sticky), .uf_hint(uf_hint), .sign(sign), .rm(rm), .fmt(fmt),
    .round_result(round_result), .round_flags(round_flags)
  );

  // Forced result overrides rounding
  assign sel_result = special_hit ? special_result : round_result;
  assign sel_flags  = special_hit ? special_flags  : round_flags;

  // Output stage, holds until next strobe
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      out_valid <= 1'b0;
      result    <= '0;
      flags     <= '0;
    end
    else
    begin
      out_valid <= in_valid;
      if (in_valid)
      begin
        result <= sel_result;
        flags  <= sel_flags;
      end
    end
  end

endmodule

`default_nettype wire

/* source/norm_special_case.sv */
// Exception priority chain with overflow test, forced result and nv, dz, of flags
`default_nettype none

module norm_special_case (
  input  fp_format_pkg::op_e      op,
  input  logic                    sign,
  input  fp_format_pkg::exp_ext_t exp_in,
  input  fp_format_pkg::fmt_e     fmt,
  input  logic                    nan_a,
  input  logic                    nan_b,
  input  logic                    snan,     // Signalling NaN seen upstream
  input  logic                    inf_a,
  input  logic                    inf_b,
  input  logic                    zero_a,
  input  logic                    zero_b,
  output logic                    special_hit,
  output fp_round_pkg::result_t   special_result,
  output fp_round_pkg::flags_t    special_flags
);

  // Kind of forced result
  typedef enum logic [1:0] {
    KIND_NONE,
    KIND_NAN,
    KIND_INF,
    KIND_ZERO
  } kind_e;

  kind_e kind;
  logic  is_div;
  logic  is16;
  logic  exp_ovf;  // Exponent already past the format range

  assign is_div = (op == fp_format_pkg::OP_DIV);
  assign is16   = (fmt == fp_format_pkg::FMT_FP16);

  // Signed compare, negative exponents never overflow
  assign exp_ovf = is16 ?
    (exp_in >= fp_format_pkg::exp_ext_t'(fp_format_pkg::EXP_MAX16)) :
    (exp_in >= fp_format_pkg::exp_ext_t'(fp_format_pkg::EXP_MAX32));

  ////////////////////////////////////////////////////////////////////////////
  // Priority chain, first match wins
  ////////////////////////////////////////////////////////////////////////////
  always_comb
  begin
    kind          = KIND_NONE;
    special_flags = '0;
    if (nan_a || nan_b)
    begin
      kind             = KIND_NAN;
      special_flags.nv = snan;  // Quiet NaN in passes silently
    end
    else if (inf_a)
    begin
      if ((is_div && inf_b) || (!is_div && sign))  // inf/inf or sqrt(-inf)
      begin
        kind             = KIND_NAN;
        special_flags.nv = 1'b1;
      end
      else
      begin
        kind             = KIND_INF;
        special_flags.of = 1'b1;
      end
    end
    else if (is_div && inf_b)
    begin
      kind             = KIND_ZERO;  // x/inf
      special_flags.of = 1'b1;
    end
    else if (zero_a)
    begin
      if (is_div && zero_b)
      begin
        kind             = KIND_NAN;  // 0/0
        special_flags.nv = 1'b1;
        special_flags.dz = 1'b1;
      end
      else
        kind = KIND_ZERO;
    end
    else if (is_div && zero_b)
    begin
      kind             = KIND_INF;  // x/0
      special_flags.dz = 1'b1;
    end
    else if (!is_div && sign)
    begin
      kind             = KIND_NAN;  // sqrt of negative
      special_flags.nv = 1'b1;
    end
    else if (exp_ovf)
    begin
      kind             = KIND_INF;
      special_flags.of = 1'b1;
    end
  end

  assign special_hit = (kind != KIND_NONE);

  // Result patterns per format, NaN always positive
  always_comb
  begin
    case (kind)
      KIND_NAN:
        special_result = is16 ? fp_round_pkg::QNAN16 : fp_round_pkg::QNAN32;
      KIND_INF:
        special_result = is16 ?
          {fp_round_pkg::BOX16, sign, {fp_format_pkg::EXP16_W{1'b1}},
           {fp_format_pkg::MANT16_W{1'b0}}} :
          {sign, {fp_format_pkg::EXP_W{1'b1}}, {fp_format_pkg::MANT_W{1'b0}}};
      KIND_ZERO:
        special_result = is16 ?
          {fp_round_pkg::BOX16, sign,
           {(fp_format_pkg::EXP16_W + fp_format_pkg::MANT16_W){1'b0}}} :
          {sign, {(fp_format_pkg::EXP_W + fp_format_pkg::MANT_W){1'b0}}};
      default:
        special_result = '0;  // Unused, rounded path selected
    endcase
  end

endmodule

`default_nettype wire

/* test/norm_round_unit_assertions.sv */
// Bound assertions on out_valid latency, reset state, of/uf exclusion and nv result
`default_nettype none

module norm_round_unit_assertions (
  input logic                  clk,
  input logic                  arst_n,
  input logic                  in_valid,
  input logic                  out_valid,
  input fp_round_pkg::result_t result,
  input fp_round_pkg::flags_t  flags
);

  int unsigned fail_cnt = 0;  // Failed assertion count

  ////////////////////////////////////////////////////////////////////////////
  // Strobe timing
  ////////////////////////////////////////////////////////////////////////////
  a_latency: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid == $past(in_valid))  // Exactly one cycle
    else
    begin
      $error("out_valid does not follow in_valid by one cycle");
      fail_cnt++;
    end

  a_reset_low: assert property (@(posedge clk) !arst_n |-> !out_valid)
    else
    begin
      $error("out_valid high during reset");
      fail_cnt++;
    end

  // Flag consistency
  a_of_uf: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid |-> !(flags.of && flags.uf))
    else
    begin
      $error("of and uf set together");
      fail_cnt++;
    end

  a_nv_nan: assert property (@(posedge clk) disable iff (!arst_n)
    (out_valid && flags.nv) |->
      ((result == fp_round_pkg::QNAN32) || (result == fp_round_pkg::QNAN16)))
    else
    begin
      $error("nv set without a canonical NaN result");
      fail_cnt++;
    end

endmodule

bind norm_round_unit norm_round_unit_assertions u_assertions (
  .clk(clk), .arst_n(arst_n), .in_valid(in_valid),
  .out_valid(out_valid), .result(result), .flags(flags)
);

`default_nettype wire

/* test/tb_norm_round_unit.sv */
// Testbench with stimulus table, expected queue, compare tasks, idle-gap LCG and timeout
`default_nettype none

module tb_norm_round_unit;

  localparam int unsigned RST_CYCLES = 10;

  // Short names for table rows
  localparam fp_format_pkg::op_e  DIV  = fp_format_pkg::OP_DIV;
  localparam fp_format_pkg::op_e  SQRT = fp_format_pkg::OP_SQRT;
  localparam fp_format_pkg::fmt_e F32  = fp_format_pkg::FMT_FP32;
  localparam fp_format_pkg::fmt_e F16  = fp_format_pkg::FMT_FP16;
  localparam fp_round_pkg::rm_e   RNE  = fp_round_pkg::RM_RNE;
  localparam fp_round_pkg::rm_e   RTZ  = fp_round_pkg::RM_RTZ;
  localparam fp_round_pkg::rm_e   RDN  = fp_round_pkg::RM_RDN;
  localparam fp_round_pkg::rm_e   RUP  = fp_round_pkg::RM_RUP;

  typedef struct packed {
    fp_format_pkg::op_e       op;
    fp_format_pkg::fmt_e      fmt;
    fp_round_pkg::rm_e        rm;
    logic                     sign;
    fp_format_pkg::mant_ext_t mant;
    fp_format_pkg::exp_ext_t  exp;
    logic [6:0]               cls;  // nan_a nan_b snan inf_a inf_b zero_a zero_b
    fp_round_pkg::result_t    res;  // Expected
    fp_round_pkg::flags_t     flg;  // Expected
  } entry_t;

  logic                     clk = 1'b0;
  logic                     arst_n;
  logic                     in_valid;
  fp_format_pkg::op_e       op;
  fp_format_pkg::fmt_e      fmt;
  fp_round_pkg::rm_e        rm;
  logic                     sign;
  fp_format_pkg::mant_ext_t mant_in;
  fp_format_pkg::exp_ext_t  exp_in;
  logic                     nan_a, nan_b, snan, inf_a, inf_b, zero_a, zero_b;
  logic                     out_valid;
  fp_round_pkg::result_t    result;
  fp_round_pkg::flags_t     flags;

  entry_t       vectors[$];
  entry_t       exp_q[$];           // Strobed, not yet seen at the output
  entry_t       cur;
  int           checked_cnt = 0;
  logic         strobe_q = 1'b0;    // in_valid as the DUT captured it
  logic [31:0]  lcg_state = 32'haf49;
  int unsigned  cycle_cnt = 0;
  int unsigned  timeout_cycles = 0;

  norm_round_unit u_dut (
    .clk(clk), .arst_n(arst_n), .in_valid(in_valid),
    .op(op), .fmt(fmt), .rm(rm), .sign(sign), .mant_in(mant_in), .exp_in(exp_in),
    .nan_a(nan_a), .nan_b(nan_b), .snan(snan), .inf_a(inf_a), .inf_b(inf_b),
    .zero_a(zero_a), .zero_b(zero_b),
    .out_valid(out_valid), .result(result), .flags(flags)
  );

  always #5 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_result(input fp_round_pkg::result_t got,
                              input fp_round_pkg::result_t want, input int idx);
    if (got !== want)
      abort_run($sformatf("** Error at %0t: entry %0d result %08h, expected %08h",
                          $time, idx, got, want));
  endtask

  task automatic check_flags(input fp_round_pkg::flags_t got,
                             input fp_round_pkg::flags_t want, input int idx);
    if (got !== want)
      abort_run($sformatf("** Error at %0t: entry %0d flags %05b, expected %05b",
                          $time, idx, got, want));
  endtask

  task automatic add_entry(input fp_format_pkg::op_e op_v, input fp_format_pkg::fmt_e fmt_v,
                           input fp_round_pkg::rm_e rm_v, input logic sign_v,
                           input fp_format_pkg::mant_ext_t mant_v,
                           input fp_format_pkg::exp_ext_t exp_v, input logic [6:0] cls_v,
                           input fp_round_pkg::result_t res_v,
                           input fp_round_pkg::flags_t flg_v);
    entry_t e;
    e = '{op_v, fmt_v, rm_v, sign_v, mant_v, exp_v, cls_v, res_v, flg_v};
    vectors.push_back(e);
  endtask

  // Expected values worked out by hand, flags are nv dz of uf nx
  task automatic build_table();
    // Specials
    add_entry(DIV,  F32, RNE, 0, 28'h8000000, 127, 7'b1000000, 32'h7fc0_0000, 5'b00000);
    add_entry(DIV,  F16, RNE, 0, 28'h8000000, 15,  7'b0110000, 32'hffff_7e00, 5'b10000);
    add_entry(DIV,  F32, RNE, 0, 28'h8000000, 127, 7'b0000011, 32'h7fc0_0000, 5'b11000);
    add_entry(DIV,  F32, RNE, 1, 28'h8000000, 127, 7'b0001100, 32'h7fc0_0000, 5'b10000);
    add_entry(SQRT, F32, RNE, 1, 28'h8000000, 127, 7'b0000000, 32'h7fc0_0000, 5'b10000);
    add_entry(SQRT, F16, RNE, 1, 28'h8000000, 15,  7'b0001000, 32'hffff_7e00, 5'b10000);
    add_entry(DIV,  F32, RNE, 1, 28'h8000000, 127, 7'b0000001, 32'hff80_0000, 5'b01000);
    add_entry(DIV,  F32, RNE, 0, 28'h8000000, 127, 7'b0001000, 32'h7f80_0000, 5'b00100);
    add_entry(DIV,  F32, RNE, 1, 28'h8000000, 127, 7'b0000010, 32'h8000_0000, 5'b00000);
    add_entry(DIV,  F32, RNE, 1, 28'h8000000, 127, 7'b0000100, 32'h8000_0000, 5'b00100);
    add_entry(SQRT, F32, RNE, 0, 28'h8000000, 127, 7'b0000010, 32'h0000_0000, 5'b00000);
    // Guard and sticky set, LSB even
    add_entry(DIV,  F32, RNE, 0, 28'h8000009, 127, 7'b0000000, 32'h3f80_0001, 5'b00001);
    add_entry(DIV,  F32, RNE, 1, 28'h8000009, 127, 7'b0000000, 32'hbf80_0001, 5'b00001);
    add_entry(DIV,  F32, RTZ, 0, 28'h8000009, 127, 7'b0000000, 32'h3f80_0000, 5'b00001);
    add_entry(DIV,  F32, RTZ, 1, 28'h8000009, 127, 7'b0000000, 32'hbf80_0000, 5'b00001);
    add_entry(DIV,  F32, RDN, 0, 28'h8000009, 127, 7'b0000000, 32'h3f80_0000, 5'b00001);
    add_entry(DIV,  F32, RDN, 1, 28'h8000009, 127, 7'b0000000, 32'hbf80_0001, 5'b00001);
    add_entry(DIV,  F32, RUP, 0, 28'h8000009, 127, 7'b0000000, 32'h3f80_0001, 5'b00001);
    add_entry(DIV,  F32, RUP, 1, 28'h8000009, 127, 7'b0000000, 32'hbf80_0000, 5'b00001);
    // Ties, odd then even LSB
    add_entry(DIV,  F32, RNE, 0, 28'h8000018, 127, 7'b0000000, 32'h3f80_0002, 5'b00001);
    add_entry(DIV,  F32, RNE, 1, 28'h8000018, 127, 7'b0000000, 32'hbf80_0002, 5'b00001);
    add_entry(DIV,  F32, RTZ, 0, 28'h8000018, 127, 7'b0000000, 32'h3f80_0001, 5'b00001);
    add_entry(DIV,  F32, RTZ, 1, 28'h8000018, 127, 7'b0000000, 32'hbf80_0001, 5'b00001);
    add_entry(DIV,  F32, RDN, 0, 28'h8000018, 127, 7'b0000000, 32'h3f80_0001, 5'b00001);
    add_entry(DIV,  F32, RDN, 1, 28'h8000018, 127, 7'b0000000, 32'hbf80_0002, 5'b00001);
    add_entry(DIV,  F32, RUP, 0, 28'h8000018, 127, 7'b0000000, 32'h3f80_0002, 5'b00001);
    add_entry(DIV,  F32, RUP, 1, 28'h8000018, 127, 7'b0000000, 32'hbf80_0001, 5'b00001);
    add_entry(DIV,  F32, RNE, 0, 28'h8000008, 127, 7'b0000000, 32'h3f80_0000, 5'b00001);
    // Exact, carry out, left normalize, overflow
    add_entry(DIV,  F32, RNE, 0, 28'hc000000, 127, 7'b0000000, 32'h3fc0_0000, 5'b00000);
    add_entry(DIV,  F32, RNE, 0, 28'hffffff8, 127, 7'b0000000, 32'h4000_0000, 5'b00001);
    add_entry(DIV,  F32, RNE, 0, 28'h4000000, 127, 7'b0000000, 32'h3f00_0000, 5'b00000);
    add_entry(DIV,  F32, RNE, 0, 28'h8000000, 255, 7'b0000000, 32'h7f80_0000, 5'b00100);
    // FP16, boxed
    add_entry(DIV,  F16, RNE, 0, 28'h8010001, 15,  7'b0000000, 32'hffff_3c01, 5'b00001);
    add_entry(DIV,  F16, RTZ, 1, 28'h8010001, 15,  7'b0000000, 32'hffff_bc00, 5'b00001);
    add_entry(DIV,  F16, RNE, 0, 28'h8000000, 15,  7'b0000000, 32'hffff_3c00, 5'b00000);
    add_entry(DIV,  F16, RNE, 0, 28'h8000000, 31,  7'b0000000, 32'hffff_7c00, 5'b00100);
    add_entry(DIV,  F16, RTZ, 1, 28'h8000000, 31,  7'b0000000, 32'hffff_fc00, 5'b00100);
    // Denormals, shift by 1 - exp
    add_entry(DIV,  F32, RNE, 0, 28'h8000000, 0,   7'b0000000, 32'h0040_0000, 5'b00010);
    add_entry(DIV,  F32, RNE, 0, 28'h8000000, -2,  7'b0000000, 32'h0010_0000, 5'b00010);
    add_entry(DIV,  F32, RUP, 0, 28'h8000020, -1,  7'b0000000, 32'h0020_0001, 5'b00011);
    add_entry(DIV,  F32, RNE, 0, 28'h8000020, -1,  7'b0000000, 32'h0020_0000, 5'b00011);
  endtask

  task automatic apply_entry(input entry_t e);
    op       <= e.op;
    fmt      <= e.fmt;
    rm       <= e.rm;
    sign     <= e.sign;
    mant_in  <= e.mant;
    exp_in   <= e.exp;
    {nan_a, nan_b, snan, inf_a, inf_b, zero_a, zero_b} <= e.cls;
    in_valid <= 1'b1;
    exp_q.push_back(e);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Output monitor, sampled on the falling edge
  ////////////////////////////////////////////////////////////////////////////
  always @(posedge clk)
    strobe_q <= in_valid;

  always @(negedge clk)
  begin
    if (strobe_q && out_valid !== 1'b1)
      abort_run($sformatf("Missing out_valid one cycle after a strobe, time %0t", $time));
    else if (!strobe_q && out_valid !== 1'b0)
      abort_run($sformatf("out_valid high without a strobe, time %0t", $time));
    else if (out_valid)
    begin
      cur = exp_q.pop_front();
      check_result(result, cur.res, checked_cnt);
      check_flags(flags, cur.flg, checked_cnt);
      checked_cnt++;
    end
  end

  // Bound checker failures end the run too
  always @(negedge clk)
  begin
    if (u_dut.u_assertions.fail_cnt != 0)
      abort_run($sformatf("A bound assertion failed before time %0t", $time));
  end

  // Run length guard
  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= timeout_cycles)
      abort_run($sformatf("Timeout after %0d cycles, outputs still pending", cycle_cnt));
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////
  initial
  begin
    int          i;
    int unsigned gap;
    arst_n   <= 1'b0;
    in_valid <= 1'b0;
    op       <= DIV;
    fmt      <= F32;
    rm       <= RNE;
    sign     <= 1'b0;
    mant_in  <= '0;
    exp_in   <= '0;
    {nan_a, nan_b, snan, inf_a, inf_b, zero_a, zero_b} <= '0;
    build_table();
    timeout_cycles = vectors.size() * 5 + RST_CYCLES + 20;

    repeat (RST_CYCLES) @(posedge clk);
    arst_n <= 1'b1;

    for (i = 0; i < vectors.size(); i++)
    begin
      gap = lcg_next() >> 30;  // 0 to 3 idle cycles
      repeat (gap)
      begin
        @(posedge clk);
        in_valid <= 1'b0;
      end
      @(posedge clk);
      apply_entry(vectors[i]);  // Back to back when gap is zero
    end
    @(posedge clk);
    in_valid <= 1'b0;

    while (exp_q.size() != 0)
      @(negedge clk);
    repeat (2) @(negedge clk);  // Catch a stray strobe

    if (u_dut.u_assertions.fail_cnt == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
source/fp_format_pkg.sv
source/fp_round_pkg.sv
source/norm_special_case.sv
source/norm_mant_align.sv
source/norm_round_pack.sv
source/norm_round_unit.sv
test/norm_round_unit_assertions.sv
test/tb_norm_round_unit.sv
